// ==== source/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

    // cpu side operation codes, same encoding as the cpu memory handler
    typedef enum logic [1:0] {
        op_idle  = 2'b00,
        op_write = 2'b01,
        op_read  = 2'b10,
        op_fetch = 2'b11
    } mmio_op_t;

    // upper bounds of each address window, all inclusive
    localparam logic [31:0] fetch_top = 32'd1024; // instruction fetch window
    localparam logic [31:0] reg_top   = 32'd1056; // external register bank
    localparam logic [31:0] mem_top   = 32'd1792; // data memory
    localparam logic [31:0] tft_top   = 32'd2047; // serial tft display

    // tag byte that marks a memory address on the bus
    localparam logic [7:0] mem_tag = 8'h33;

    // request as presented by the cpu core
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        mmio_op_t    op;
    } cpu_req_t;

    // single transfer toward the bus master and on to memory
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // address and data shifted out to the display, addr goes first
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } tft_cmd_t;

endpackage

`default_nettype wire

// ==== source/mmio_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_decoder (
    input  mmio_pkg::cpu_req_t req,          // held by the cpu while busy
    input  logic               bus_busy,     // bus master still waiting on memory
    input  logic [31:0]        bus_rdata,    // valid in the ack cycle
    input  logic [31:0]        reg_rdata,
    input  logic               reg_ack,
    input  logic               reg_chip_sel, // low while the bank is being loaded
    input  logic               tft_ack,      // high while a frame is shifting
    output mmio_pkg::bus_req_t bus,
    output logic               ri,
    output logic [4:0]         reg_addr,
    output logic               wi,
    output mmio_pkg::tft_cmd_t tft,
    output logic               busy,
    output logic [31:0]        rdata,
    output logic [31:0]        instr
);
    import mmio_pkg::*;

    logic        in_fetch;
    logic        in_reg;
    logic        in_mem;
    logic        in_tft;
    logic [31:0] mem_addr;
    logic        reg_wait; // register read not finished yet

    // window decode, boundaries follow the address map in the package
    assign in_fetch = (req.addr <= fetch_top);
    assign in_reg   = (req.addr > fetch_top) && (req.addr <= reg_top);
    assign in_mem   = (req.addr > reg_top) && (req.addr <= mem_top);
    assign in_tft   = (req.addr > mem_top) && (req.addr <= tft_top);

    // memory sees only the low 24 bits behind the tag byte
    assign mem_addr = {mem_tag, req.addr[23:0]};

    always_comb begin
        bus      = '0; // nothing on the bus by default
        ri       = 1'b0;
        reg_addr = '0;
        wi       = 1'b0;
        tft      = '0;
        rdata    = '0;
        instr    = '0;
        reg_wait = 1'b0;

        // a frame in flight stalls everything, so each request goes out once
        if (!tft_ack) begin
            case (req.op)
                op_fetch: begin
                    if (in_fetch) begin
                        bus.read = 1'b1;
                        bus.addr = mem_addr;
                        instr    = bus_rdata; // next instruction for fetch
                    end
                end
                op_read: begin
                    if (in_reg) begin
                        reg_addr = req.addr[4:0];
                        if (reg_chip_sel) begin
                            ri       = 1'b1;
                            rdata    = reg_rdata;
                            reg_wait = !reg_ack; // done once the bank acks
                        end else begin
                            reg_wait = 1'b1; // load in progress, hold off
                        end
                    end else if (in_mem) begin
                        bus.read = 1'b1;
                        bus.addr = mem_addr;
                        rdata    = bus_rdata;
                    end
                end
                op_write: begin
                    if (in_mem) begin
                        bus.write = 1'b1;
                        bus.addr  = mem_addr;
                        bus.wdata = req.wdata;
                    end else if (in_tft) begin
                        wi       = 1'b1;        // port takes it only when idle
                        tft.addr = req.addr;
                        tft.data = req.wdata;
                    end
                    // register window is load-only, write dropped here
                end
                default: ; // idle, nothing to route
            endcase
        end

        // three sources can stall the cpu
        busy = tft_ack | bus_busy | reg_wait;
    end

endmodule

`default_nettype wire

// ==== source/bus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_master (
    input  logic               clk,
    input  logic               reset,
    input  mmio_pkg::bus_req_t cmd,       // from the decoder
    input  logic               ack,       // memory finished the transfer
    input  logic [31:0]        mem_rdata,
    output mmio_pkg::bus_req_t mem,       // held steady toward memory
    output logic               stb,
    output logic               busy,
    output logic [31:0]        rdata
);
    import mmio_pkg::*;

    typedef enum logic {
        st_idle,
        st_active
    } state_t;

    state_t   state;
    bus_req_t held;  // request captured at start of transfer
    logic     start;

    // a read or write seen while idle opens a new transfer
    assign start = (state == st_idle) && (cmd.read || cmd.write);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (start) state <= st_active;
                st_active: if (ack) state <= st_idle; // one transfer per request
                default:   state <= st_idle;
            endcase
        end
    end

    // address and data stay frozen until ack
    always_ff @(posedge clk) begin
        if (start) begin
            held <= cmd;
        end
    end

    assign stb = (state == st_active); // high until ack, then drops

    assign mem.read  = stb & held.read;
    assign mem.write = stb & held.write;
    assign mem.addr  = held.addr;
    assign mem.wdata = held.wdata;

    // busy covers the request cycle and every wait cycle, not the ack cycle
    always_comb begin
        case (state)
            st_idle:   busy = start;
            st_active: busy = !ack;
            default:   busy = 1'b0;
        endcase
    end

    assign rdata = ack ? mem_rdata : '0; // only meaningful with ack

endmodule

`default_nettype wire

// ==== source/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int mem_words = 1024,
    parameter int mem_wait  = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  mmio_pkg::bus_req_t bus,
    input  logic               stb,
    output logic               ack,
    output logic [31:0]        rdata
);
    import mmio_pkg::*;

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = (mem_wait > 0) ? $clog2(mem_wait + 1) : 1;

    logic [31:0]      words [mem_words];
    logic [cnt_w-1:0] wait_cnt; // cycles of stb seen so far
    logic             tag_ok;
    logic [idx_w-1:0] idx;      // upper address bits alias onto the array

    // starts out all zero
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            words[i] = '0;
        end
    end

    assign tag_ok = (bus.addr[31:24] == mem_tag);
    assign idx    = bus.addr[idx_w-1:0];

    // ack after mem_wait cycles of strobe
    assign ack = stb && (wait_cnt == cnt_w'(mem_wait));

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (!stb || ack) begin
            wait_cnt <= '0; // rearm for next transfer
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ack && bus.write && tag_ok) begin
            words[idx] <= bus.wdata; // write lands at ack
        end
    end

    assign rdata = (ack && bus.read && tag_ok) ? words[idx] : '0; // untagged reads zero

endmodule

`default_nettype wire

// ==== source/ext_register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_register_bank #(
    parameter int reg_count = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,      // external load strobe
    input  logic [$clog2(reg_count)-1:0] load_addr,
    input  logic [31:0]                  load_data,
    input  logic                         ri,        // cpu read request
    input  logic [$clog2(reg_count)-1:0] addr,
    output logic                         chip_sel,
    output logic                         ack,
    output logic [31:0]                  rdata
);
    logic [31:0] regs [reg_count];

    // cpu may not read in the cycle a load is written
    assign chip_sel = !load;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0; // status registers come up cleared
            end
        end else begin
            if (load) begin
                regs[load_addr] <= load_data;
            end
            // one cycle pulse, then low again before the next read
            ack <= ri && chip_sel && !ack;
        end
    end

    // captured with the read so it lines up with ack
    always_ff @(posedge clk) begin
        if (ri && chip_sel) begin
            rdata <= regs[addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/tft_serial_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module tft_serial_port #(
    parameter int tft_clk_div = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wi,   // write request from the decoder
    input  mmio_pkg::tft_cmd_t cmd,
    output logic               ack,  // high for the whole frame
    output logic               sclk,
    output logic               mosi,
    output logic               cs_n
);
    localparam int div_w = (tft_clk_div > 1) ? $clog2(tft_clk_div) : 1;

    logic             active;
    logic             sclk_q;   // serial clock, idles low (mode 0)
    logic [div_w-1:0] div_cnt;  // system cycles within a half period
    logic [5:0]       bit_cnt;  // bits fully sent
    logic [63:0]      shreg;
    logic             tick;     // half period boundary
    logic             take;     // new frame accepted

    assign tick = active && (div_cnt == div_w'(tft_clk_div - 1));
    assign take = !active && wi; // ignored while a frame is in flight

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            sclk_q  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (take) begin
            active  <= 1'b1;
            sclk_q  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            sclk_q  <= !sclk_q;
            if (sclk_q) begin // falling edge closes a bit
                if (bit_cnt == 6'd63) begin
                    active <= 1'b0; // last bit done
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else if (active) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // address in the upper half, msb leaves first
    always_ff @(posedge clk) begin
        if (take) begin
            shreg <= {cmd.addr, cmd.data};
        end else if (tick && sclk_q) begin
            shreg <= {shreg[62:0], 1'b0}; // next bit ready before the rise
        end
    end

    assign ack  = active;
    assign cs_n = !active;
    assign sclk = sclk_q;
    assign mosi = active & shreg[63];

endmodule

`default_nettype wire

// ==== source/mmio_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_subsystem #(
    parameter int mem_words   = 1024,
    parameter int mem_wait    = 2,
    parameter int reg_count   = 32,
    parameter int tft_clk_div = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  mmio_pkg::cpu_req_t           req,
    input  logic                         reg_load,
    input  logic [$clog2(reg_count)-1:0] reg_load_addr,
    input  logic [31:0]                  reg_load_data,
    output logic                         busy,
    output logic [31:0]                  rdata,
    output logic [31:0]                  instr,
    output logic                         tft_sclk,
    output logic                         tft_mosi,
    output logic                         tft_cs_n
);
    import mmio_pkg::*;

    bus_req_t    dec_bus;    // decoder to bus master
    bus_req_t    mem_bus;    // bus master to memory
    logic        bus_busy;
    logic [31:0] bus_rdata;
    logic        mem_stb;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        reg_ri;
    logic [4:0]  reg_addr;
    logic        reg_chip_sel;
    logic        reg_ack;
    logic [31:0] reg_rdata;
    logic        tft_wi;
    tft_cmd_t    tft_cmd;
    logic        tft_ack;

    mmio_decoder u_decoder (
        .req(req), .bus_busy(bus_busy), .bus_rdata(bus_rdata),
        .reg_rdata(reg_rdata), .reg_ack(reg_ack), .reg_chip_sel(reg_chip_sel),
        .tft_ack(tft_ack), .bus(dec_bus), .ri(reg_ri), .reg_addr(reg_addr),
        .wi(tft_wi), .tft(tft_cmd), .busy(busy), .rdata(rdata), .instr(instr)
    );

    bus_master u_bus_master (
        .clk(clk), .reset(reset), .cmd(dec_bus), .ack(mem_ack),
        .mem_rdata(mem_rdata), .mem(mem_bus), .stb(mem_stb),
        .busy(bus_busy), .rdata(bus_rdata)
    );

    data_memory #(.mem_words(mem_words), .mem_wait(mem_wait)) u_memory (
        .clk(clk), .reset(reset), .bus(mem_bus), .stb(mem_stb),
        .ack(mem_ack), .rdata(mem_rdata)
    );

    // decoder always drives five address bits, bank sized to 32 entries
    ext_register_bank #(.reg_count(reg_count)) u_reg_bank (
        .clk(clk), .reset(reset), .load(reg_load), .load_addr(reg_load_addr),
        .load_data(reg_load_data), .ri(reg_ri), .addr(reg_addr),
        .chip_sel(reg_chip_sel), .ack(reg_ack), .rdata(reg_rdata)
    );

    tft_serial_port #(.tft_clk_div(tft_clk_div)) u_tft (
        .clk(clk), .reset(reset), .wi(tft_wi), .cmd(tft_cmd), .ack(tft_ack),
        .sclk(tft_sclk), .mosi(tft_mosi), .cs_n(tft_cs_n)
    );

endmodule

`default_nettype wire

// ==== bench/tb_mmio.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mmio;
    import mmio_pkg::*;

    localparam int mem_words   = 1024;
    localparam int mem_wait    = 2;
    localparam int reg_count   = 32;
    localparam int tft_clk_div = 2;
    localparam int max_vec     = 64;
    localparam int n_pairs     = 8;    // random write/read pairs after the vectors

    logic        clk;
    logic        reset;
    cpu_req_t    req;
    logic        reg_load;
    logic [4:0]  reg_load_addr;
    logic [31:0] reg_load_data;
    logic        busy;
    logic [31:0] rdata;
    logic [31:0] instr;
    logic        tft_sclk;
    logic        tft_mosi;
    logic        tft_cs_n;

    logic [31:0] vec_words [0:max_vec*5-1];   // five words per vector line
    logic [31:0] shadow [logic [31:0]];       // expected memory for random pairs
    logic [63:0] rx_frame = '0;               // last 64 bits seen on the serial line
    int          rx_count = 0;
    int          cycles   = 0;
    int          limit;
    int          n_vec;

    mmio_subsystem #(
        .mem_words(mem_words), .mem_wait(mem_wait),
        .reg_count(reg_count), .tft_clk_div(tft_clk_div)
    ) u_dut (
        .clk(clk), .reset(reset), .req(req), .reg_load(reg_load),
        .reg_load_addr(reg_load_addr), .reg_load_data(reg_load_data),
        .busy(busy), .rdata(rdata), .instr(instr),
        .tft_sclk(tft_sclk), .tft_mosi(tft_mosi), .tft_cs_n(tft_cs_n)
    );

    always #50 clk = ~clk;

    // display side receiver samples on the rising serial clock (mode 0)
    always @(posedge tft_sclk) begin
        if (!tft_cs_n) begin
            rx_frame = {rx_frame[62:0], tft_mosi};
            rx_count = rx_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            report_failure($sformatf("timeout, run exceeded %0d cycles", limit));
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // busy cycles each window takes after the request
    function automatic int expected_latency(input logic [1:0] op, input logic [31:0] addr);
        if (op == op_fetch && addr <= fetch_top) return mem_wait + 1;
        if ((op == op_write || op == op_read) && addr > reg_top && addr <= mem_top)
            return mem_wait + 1;
        if (op == op_read && addr > fetch_top && addr <= reg_top) return 1;
        return 0; // everything else is dropped by the decoder
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got, input int idx);
        assert (got === exp) else
            report_failure($sformatf("CHECK FAILED %s at vector %0d: expected %h got %h",
                                     name, idx, exp, got));
    endtask

    task automatic check_latency(input int lat, input int exp, input int idx);
        check_value("busy cycles", 32'(exp), 32'(lat), idx);
    endtask

    task automatic apply_request(input logic [1:0] op, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        req.addr  = addr;
        req.wdata = wdata;
        req.op    = mmio_op_t'(op);
    endtask

    // count busy cycles at mid-cycle, take results there, then release the request
    task automatic wait_done(output int lat, output logic [31:0] rd, output logic [31:0] ins);
        lat = 0;
        @(negedge clk);
        while (busy) begin
            lat++;
            @(negedge clk);
        end
        rd  = rdata;
        ins = instr;
        @(posedge clk);
        #5;
        req = '0; // back to idle
    endtask

    task automatic run_vector(input int i);
        logic [31:0] kind;
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic [31:0] rd;
        logic [31:0] ins;
        int          lat;
        int          rx_start;
        kind  = vec_words[i*5];
        op    = vec_words[i*5+1][1:0];
        addr  = vec_words[i*5+2];
        wdata = vec_words[i*5+3];
        exp   = vec_words[i*5+4];
        case (kind)
            32'h0: begin // plain request with the result on rdata
                apply_request(op, addr, wdata);
                wait_done(lat, rd, ins);
                check_latency(lat, expected_latency(op, addr), i);
                check_value("rdata", exp, rd, i);
            end
            32'h1: begin // fetch with the result on instr
                apply_request(op, addr, wdata);
                wait_done(lat, rd, ins);
                check_latency(lat, expected_latency(op, addr), i);
                check_value("instr", exp, ins, i);
            end
            32'h2: begin // one cycle external load
                reg_load      = 1'b1;
                reg_load_addr = addr[4:0];
                reg_load_data = wdata;
                @(posedge clk);
                #5;
                reg_load = 1'b0;
            end
            32'h3: begin // read lands in the same cycle as a load of that register
                apply_request(op_read, addr, '0);
                reg_load      = 1'b1;
                reg_load_addr = addr[4:0];
                reg_load_data = wdata;
                @(posedge clk);
                #5;
                reg_load = 1'b0;
                wait_done(lat, rd, ins);
                check_latency(lat, expected_latency(op_read, addr), i);
                check_value("rdata", exp, rd, i);
            end
            32'h4: begin // display write and wait for the whole frame
                rx_start = rx_count;
                apply_request(op, addr, wdata);
                wait_done(lat, rd, ins);
                @(negedge clk);
                while (busy) @(negedge clk);
                assert (rx_count - rx_start == 64) else
                    report_failure($sformatf("busy dropped after %0d of 64 serial bits",
                                             rx_count - rx_start));
                check_value("tft frame high", addr, rx_frame[63:32], i);
                check_value("tft frame low", wdata, rx_frame[31:0], i);
                check_value("tft_cs_n", 32'd1, {31'd0, tft_cs_n}, i); // deselected again
                @(posedge clk);
                #5;
            end
            default: report_failure($sformatf("unknown vector kind %h", kind));
        endcase
    endtask

    task automatic run_random_pairs();
        logic [31:0] seed;
        logic [31:0] addrs [n_pairs];
        logic [31:0] rd;
        logic [31:0] ins;
        int          lat;
        seed = 32'hb5f9bd7f;
        for (int i = 0; i < n_pairs; i++) begin
            seed     = xorshift(seed);
            addrs[i] = 32'd1057 + (seed % 32'd736); // anywhere in the data window
            seed     = xorshift(seed);
            apply_request(op_write, addrs[i], seed);
            wait_done(lat, rd, ins);
            check_latency(lat, mem_wait + 1, n_vec + i);
            shadow[addrs[i]] = seed;
        end
        // read back only after all writes so repeated addresses keep the last one
        for (int i = 0; i < n_pairs; i++) begin
            apply_request(op_read, addrs[i], '0);
            wait_done(lat, rd, ins);
            check_value("rdata", shadow[addrs[i]], rd, n_vec + i);
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        req           = '0;
        reg_load      = 1'b0;
        reg_load_addr = '0;
        reg_load_data = '0;
        limit         = 0;
        $readmemh("bench/mmio_vectors.hex", vec_words);
        if (vec_words[0] === 'x) report_failure("vector file could not be read");
        n_vec = 0;
        while (n_vec < max_vec && vec_words[n_vec*5] !== 32'hff) n_vec++;
        if (n_vec == max_vec) report_failure("vector file has no end marker");
        limit = n_vec * 300 + n_pairs * 10;
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
        end
        run_random_pairs();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/mmio_vectors.hex ====
// kind op addr wdata expected, kind 0 request/rdata, 1 fetch/instr, 2 register load,
// 3 register read during a load, 4 display write, ff ends the list
0 1 00000421 cafe0001 00000000
0 2 00000421 00000000 cafe0001
0 1 00000700 12345678 00000000
0 2 00000700 00000000 12345678
0 1 00000500 00a00093 00000000
1 3 00000100 00000000 00a00093
0 1 000006ff deadbeef 00000000
1 3 000002ff 00000000 deadbeef
1 3 00000400 00000000 00000000
1 3 00000000 00000000 00000000
2 0 00000001 5a5a0001 00000000
0 2 00000401 00000000 5a5a0001
2 0 00000000 0000beef 00000000
0 2 00000420 00000000 0000beef
3 2 00000410 77770010 77770010
0 2 00000401 00000000 5a5a0001
0 1 00000406 11111111 00000000
0 2 00000406 00000000 00000000
1 3 00000006 00000000 00000000
0 2 00000710 00000000 00000000
0 0 00000421 ffffffff 00000000
0 2 00000421 00000000 cafe0001
4 1 00000701 a5c3f00f 00000000
4 1 000007ff 13579bdf 00000000
ff 0 00000000 00000000 00000000

// ==== vlog.f ====
source/mmio_pkg.sv
source/mmio_decoder.sv
source/bus_master.sv
source/data_memory.sv
source/ext_register_bank.sv
source/tft_serial_port.sv
source/mmio_subsystem.sv
bench/tb_mmio.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mmio -f vlog.f -o tb_mmio_sim || exit 1
out=$(./obj_dir/tb_mmio_sim)
echo "$out"
echo "$out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
